// File: Makefile
# Verilator build and run of the bit-manipulation unit testbench
TOP := tb_bmu_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f bmu_top.f --top-module $(TOP) -Mdir obj_dir

# The run passes only when the pass line shows up in the simulator output
run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --assert -f bmu_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: b_alu.sv
// Second pipeline stage, computes every bit-manipulation operation and registers the unit result
`timescale 1ns/10ps
`default_nettype none

`include "bmu_config.svh"

module b_alu (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  bmu_pkg::id_ex_t      id_ex_i,   // From decode stage
  output bmu_pkg::bmu_result_t result_o
);

  localparam int XLEN  = `BMU_XLEN;
  localparam int SH_W  = $clog2(XLEN);    // Shift and bit index width
  localparam int CNT_W = $clog2(XLEN) + 1; // Counts reach XLEN

  logic [XLEN-1:0]   op_a;
  logic [XLEN-1:0]   op_b;
  logic [SH_W-1:0]   shamt;      // Rotate amount and bit index
  logic [XLEN-1:0]   op_a_rev;   // Bit-reversed a, feeds ctz
  logic [XLEN-1:0]   bit_mask;   // One-hot at shamt
  logic [2*XLEN-1:0] rot_l;
  logic [2*XLEN-1:0] rot_r;
  logic [CNT_W-1:0]  clz_cnt;
  logic [CNT_W-1:0]  ctz_cnt;
  logic [CNT_W-1:0]  cpop_cnt;
  logic [XLEN-1:0]   orc_res;
  logic [XLEN-1:0]   rev8_res;
  logic [XLEN-1:0]   alu_res;
  bmu_pkg::bmu_result_t result_d;
  bmu_pkg::bmu_result_t result_q;

  // Leading zeros, XLEN for a zero input
  function automatic logic [CNT_W-1:0] count_lz(input logic [XLEN-1:0] val);
    logic [CNT_W-1:0] cnt;
    logic             found;
    cnt   = '0;
    found = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (val[i]) begin
        found = 1'b1;
      end else if (!found) begin
        cnt = cnt + 1'b1;
      end
    end
    return cnt;
  endfunction

  assign op_a     = id_ex_i.operand_a;
  assign op_b     = id_ex_i.operand_b;
  assign shamt    = op_b[SH_W-1:0]; // Upper bits ignored
  assign bit_mask = {{(XLEN-1){1'b0}}, 1'b1} << shamt;
  assign rot_l    = {op_a, op_a} << shamt;
  assign rot_r    = {op_a, op_a} >> shamt;

  //////////////////////////////
  // Unary helpers
  //////////////////////////////

  always_comb begin
    cpop_cnt = '0;
    for (int i = 0; i < XLEN; i++) begin
      op_a_rev[i] = op_a[XLEN-1-i];
      cpop_cnt    = cpop_cnt + {{(CNT_W-1){1'b0}}, op_a[i]};
    end
    for (int b = 0; b < XLEN / 8; b++) begin
      orc_res[8*b +: 8]  = (|op_a[8*b +: 8]) ? 8'hff : 8'h00;
      rev8_res[8*b +: 8] = op_a[XLEN-8-8*b +: 8]; // Byte b swaps with its mirror
    end
  end

  assign clz_cnt = count_lz(op_a);
  assign ctz_cnt = count_lz(op_a_rev); // Trailing zeros of a are leading zeros of reversed a

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    case (id_ex_i.op)
      bmu_pkg::ALU_B_SH1ADD: alu_res = (op_a << 1) + op_b;
      bmu_pkg::ALU_B_SH2ADD: alu_res = (op_a << 2) + op_b;
      bmu_pkg::ALU_B_SH3ADD: alu_res = (op_a << 3) + op_b;
      bmu_pkg::ALU_B_MIN:    alu_res = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
      bmu_pkg::ALU_B_MINU:   alu_res = (op_a < op_b) ? op_a : op_b;
      bmu_pkg::ALU_B_MAX:    alu_res = ($signed(op_a) < $signed(op_b)) ? op_b : op_a;
      bmu_pkg::ALU_B_MAXU:   alu_res = (op_a < op_b) ? op_b : op_a;
      bmu_pkg::ALU_B_ANDN:   alu_res = op_a & ~op_b;
      bmu_pkg::ALU_B_ORN:    alu_res = op_a | ~op_b;
      bmu_pkg::ALU_B_XNOR:   alu_res = ~(op_a ^ op_b);
      bmu_pkg::ALU_B_ROL:    alu_res = rot_l[2*XLEN-1:XLEN];  // Upper copy after left shift
      bmu_pkg::ALU_B_ROR:    alu_res = rot_r[XLEN-1:0];
      bmu_pkg::ALU_B_CLZ:    alu_res = {{(XLEN-CNT_W){1'b0}}, clz_cnt};
      bmu_pkg::ALU_B_CTZ:    alu_res = {{(XLEN-CNT_W){1'b0}}, ctz_cnt};
      bmu_pkg::ALU_B_CPOP:   alu_res = {{(XLEN-CNT_W){1'b0}}, cpop_cnt};
      bmu_pkg::ALU_B_ORC_B:  alu_res = orc_res;
      bmu_pkg::ALU_B_REV8:   alu_res = rev8_res;
      bmu_pkg::ALU_B_SEXT_B: alu_res = {{(XLEN-8){op_a[7]}}, op_a[7:0]};
      bmu_pkg::ALU_B_SEXT_H: alu_res = {{(XLEN-16){op_a[15]}}, op_a[15:0]};
      bmu_pkg::ALU_B_BSET:   alu_res = op_a | bit_mask;
      bmu_pkg::ALU_B_BCLR:   alu_res = op_a & ~bit_mask;
      bmu_pkg::ALU_B_BINV:   alu_res = op_a ^ bit_mask;
      bmu_pkg::ALU_B_BEXT:   alu_res = {{(XLEN-1){1'b0}}, op_a[shamt]};
      default:               alu_res = '0;
    endcase
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_comb begin
    result_d.valid   = id_ex_i.valid;
    result_d.illegal = id_ex_i.illegal;
    result_d.rd      = id_ex_i.rd;
    result_d.data    = id_ex_i.illegal ? '0 : alu_res; // Illegal returns zero
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      result_q <= '0;
    end else if (id_ex_i.valid) begin
      result_q <= result_d;
    end else begin
      result_q.valid <= 1'b0; // Hold last data on bubbles
    end
  end

  assign result_o = result_q;

  // Consumers sample valid every cycle once out of reset
  a_valid_known : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !$isunknown(result_o.valid)
  ) else $error("Result valid is unknown after reset");

endmodule : b_alu

`default_nettype wire

// File: b_decoder.sv
// Combinational decoder of Zba, Zbb and Zbs instructions into ALU control, gated by the subset parameter
`timescale 1ns/10ps
`default_nettype none

module b_decoder #(
  parameter bmu_pkg::b_ext_e B_EXT = bmu_pkg::B_NONE
) (
  input  logic [31:0]            instr_i,        // Raw instruction word
  output bmu_pkg::decoder_ctrl_t decoder_ctrl_o  // Operator, operand select, illegal
);

  localparam logic [6:0] OPCODE_OP    = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;

  // Subset enables, Zbc adds nothing decodable here
  localparam bit EN_ZBA = (B_EXT == bmu_pkg::ZBA_ZBB_ZBS) || (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);
  localparam bit EN_ZBB = (B_EXT == bmu_pkg::ZBA_ZBB_ZBS) || (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);
  localparam bit EN_ZBS = (B_EXT == bmu_pkg::ZBA_ZBB_ZBS) || (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [4:0]         rs2_f;      // rs2 field, also shamt for immediates
  logic               hit;        // Encoding matched
  logic               ext_en;     // Owning subset is built in
  bmu_pkg::alu_op_e   op;
  bmu_pkg::op_b_sel_e op_b_sel;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign rs2_f  = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  always_comb begin
    hit      = 1'b1;
    ext_en   = 1'b0;
    op       = bmu_pkg::ALU_B_SH1ADD;
    op_b_sel = bmu_pkg::OP_B_REG;

    case (opcode)
      //////////////////////////////
      // Register-register forms
      //////////////////////////////
      OPCODE_OP: begin
        case ({funct7, funct3})
          {7'b0010000, 3'b010}: begin // sh1add
            ext_en = EN_ZBA;
            op     = bmu_pkg::ALU_B_SH1ADD;
          end
          {7'b0010000, 3'b100}: begin // sh2add
            ext_en = EN_ZBA;
            op     = bmu_pkg::ALU_B_SH2ADD;
          end
          {7'b0010000, 3'b110}: begin // sh3add
            ext_en = EN_ZBA;
            op     = bmu_pkg::ALU_B_SH3ADD;
          end
          {7'b0000101, 3'b100}: begin // min
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_MIN;
          end
          {7'b0000101, 3'b101}: begin // minu
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_MINU;
          end
          {7'b0000101, 3'b110}: begin // max
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_MAX;
          end
          {7'b0000101, 3'b111}: begin // maxu
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_MAXU;
          end
          {7'b0100000, 3'b111}: begin // andn
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_ANDN;
          end
          {7'b0100000, 3'b110}: begin // orn
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_ORN;
          end
          {7'b0100000, 3'b100}: begin // xnor
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_XNOR;
          end
          {7'b0110000, 3'b001}: begin // rol
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_ROL;
          end
          {7'b0110000, 3'b101}: begin // ror
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_ROR;
          end
          {7'b0010100, 3'b001}: begin // bset
            ext_en = EN_ZBS;
            op     = bmu_pkg::ALU_B_BSET;
          end
          {7'b0100100, 3'b001}: begin // bclr
            ext_en = EN_ZBS;
            op     = bmu_pkg::ALU_B_BCLR;
          end
          {7'b0110100, 3'b001}: begin // binv
            ext_en = EN_ZBS;
            op     = bmu_pkg::ALU_B_BINV;
          end
          {7'b0100100, 3'b101}: begin // bext
            ext_en = EN_ZBS;
            op     = bmu_pkg::ALU_B_BEXT;
          end
          default: hit = 1'b0;
        endcase
      end

      //////////////////////////////
      // Immediate and unary forms
      //////////////////////////////
      OPCODE_OPIMM: begin
        // Unary ops are told apart by the rs2 field
        casez ({funct7, rs2_f, funct3})
          {7'b0110000, 5'b00000, 3'b001}: begin // clz
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_CLZ;
          end
          {7'b0110000, 5'b00001, 3'b001}: begin // ctz
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_CTZ;
          end
          {7'b0110000, 5'b00010, 3'b001}: begin // cpop
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_CPOP;
          end
          {7'b0110000, 5'b00100, 3'b001}: begin // sext.b
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_SEXT_B;
          end
          {7'b0110000, 5'b00101, 3'b001}: begin // sext.h
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_SEXT_H;
          end
          {7'b0010100, 5'b00111, 3'b101}: begin // orc.b
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_ORC_B;
          end
          {7'b0110100, 5'b11000, 3'b101}: begin // rev8
            ext_en = EN_ZBB;
            op     = bmu_pkg::ALU_B_REV8;
          end
          {7'b0110000, 5'b?????, 3'b101}: begin // rori
            ext_en   = EN_ZBB;
            op       = bmu_pkg::ALU_B_ROR;
            op_b_sel = bmu_pkg::OP_B_IMM;
          end
          {7'b0010100, 5'b?????, 3'b001}: begin // bseti
            ext_en   = EN_ZBS;
            op       = bmu_pkg::ALU_B_BSET;
            op_b_sel = bmu_pkg::OP_B_IMM;
          end
          {7'b0100100, 5'b?????, 3'b001}: begin // bclri
            ext_en   = EN_ZBS;
            op       = bmu_pkg::ALU_B_BCLR;
            op_b_sel = bmu_pkg::OP_B_IMM;
          end
          {7'b0110100, 5'b?????, 3'b001}: begin // binvi
            ext_en   = EN_ZBS;
            op       = bmu_pkg::ALU_B_BINV;
            op_b_sel = bmu_pkg::OP_B_IMM;
          end
          {7'b0100100, 5'b?????, 3'b101}: begin // bexti
            ext_en   = EN_ZBS;
            op       = bmu_pkg::ALU_B_BEXT;
            op_b_sel = bmu_pkg::OP_B_IMM;
          end
          default: hit = 1'b0;
        endcase
      end

      default: hit = 1'b0; // Not an OP or OP-IMM word
    endcase

    // Legal only when matched and the subset is present
    decoder_ctrl_o = bmu_pkg::DECODER_CTRL_ILLEGAL;
    if (hit && ext_en) begin
      decoder_ctrl_o.illegal_insn     = 1'b0;
      decoder_ctrl_o.alu_operator     = op;
      decoder_ctrl_o.alu_op_b_mux_sel = op_b_sel;
    end
  end

endmodule : b_decoder

`default_nettype wire

// File: bmu_config.svh
// Build-time settings for the bit-manipulation unit, included by the package, the RTL and the testbench
`ifndef BMU_CONFIG_SVH
`define BMU_CONFIG_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Width of every operand and result
`define BMU_XLEN 32

//////////////////////////////
// Extension subset
//////////////////////////////

// Subset enabled at the top level and in the testbench model
`define BMU_B_EXT_DEFAULT bmu_pkg::ZBA_ZBB_ZBS

`endif

// File: bmu_decode_stage.sv
// First pipeline stage of the unit, decodes the instruction and registers the operands for the ALU
`timescale 1ns/10ps
`default_nettype none

`include "bmu_config.svh"

module bmu_decode_stage #(
  parameter bmu_pkg::b_ext_e B_EXT = bmu_pkg::B_NONE
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 valid_i,   // One strobe per instruction
  input  logic [31:0]          instr_i,
  input  logic [`BMU_XLEN-1:0] rs1_i,
  input  logic [`BMU_XLEN-1:0] rs2_i,
  output bmu_pkg::id_ex_t      id_ex_o
);

  bmu_pkg::decoder_ctrl_t dec_ctrl;
  logic [`BMU_XLEN-1:0]   shamt_imm;  // instr[24:20], zero-extended
  bmu_pkg::id_ex_t        id_ex_d;
  bmu_pkg::id_ex_t        id_ex_q;

  b_decoder #(
    .B_EXT (B_EXT)
  ) i_b_decoder (
    .instr_i        (instr_i),
    .decoder_ctrl_o (dec_ctrl)
  );

  assign shamt_imm = {{(`BMU_XLEN-5){1'b0}}, instr_i[24:20]};

  //////////////////////////////
  // Next payload
  //////////////////////////////

  always_comb begin
    id_ex_d.valid     = valid_i;
    id_ex_d.illegal   = dec_ctrl.illegal_insn;
    id_ex_d.op        = dec_ctrl.alu_operator;
    id_ex_d.rd        = instr_i[11:7];
    id_ex_d.operand_a = rs1_i;
    id_ex_d.operand_b = (dec_ctrl.alu_op_b_mux_sel == bmu_pkg::OP_B_IMM) ? shamt_imm : rs2_i;
  end

  // Payload only loads on a valid strobe, idle cycles keep it
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_ex_q.valid <= 1'b0;
    end else if (valid_i) begin
      id_ex_q <= id_ex_d;
    end else begin
      id_ex_q.valid <= 1'b0;
    end
  end

  assign id_ex_o = id_ex_q;

  // A valid legal entry must carry a known operator of alu_op_e
  a_legal_op_registered : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    id_ex_o.valid && !id_ex_o.illegal |->
      !$isunknown(id_ex_o.op) && (id_ex_o.op <= bmu_pkg::ALU_B_BEXT)
  ) else $error("Legal entry registered with an operator outside alu_op_e");

endmodule : bmu_decode_stage

`default_nettype wire

// File: bmu_pkg.sv
// Shared types and constants of the bit-manipulation unit, referenced by scoped names
`default_nettype none

`include "bmu_config.svh"

package bmu_pkg;

  //////////////////////////////
  // Extension subsets
  //////////////////////////////

  typedef enum logic [1:0] {
    B_NONE          = 2'b00, // No bit-manipulation support
    ZBA_ZBB_ZBS     = 2'b01,
    ZBA_ZBB_ZBC_ZBS = 2'b10  // Carry-less subset accepted but not decoded
  } b_ext_e;

  //////////////////////////////
  // ALU operators
  //////////////////////////////

  typedef enum logic [4:0] {
    // Zba address generation
    ALU_B_SH1ADD,
    ALU_B_SH2ADD,
    ALU_B_SH3ADD,
    // Zbb compare
    ALU_B_MIN,
    ALU_B_MINU,
    ALU_B_MAX,
    ALU_B_MAXU,
    // Zbb inverted logic
    ALU_B_ANDN,
    ALU_B_ORN,
    ALU_B_XNOR,
    // Zbb rotates
    ALU_B_ROL,
    ALU_B_ROR,
    // Zbb unary
    ALU_B_CLZ,
    ALU_B_CTZ,
    ALU_B_CPOP,
    ALU_B_ORC_B,
    ALU_B_REV8,
    ALU_B_SEXT_B,
    ALU_B_SEXT_H,
    // Zbs single-bit
    ALU_B_BSET,
    ALU_B_BCLR,
    ALU_B_BINV,
    ALU_B_BEXT  // Keep last, stage checks use it as the upper bound
  } alu_op_e;

  // Source of operand b
  typedef enum logic [0:0] {
    OP_B_REG = 1'b0, // rs2 value
    OP_B_IMM = 1'b1  // Zero-extended shamt field
  } op_b_sel_e;

  //////////////////////////////
  // Pipeline payloads
  //////////////////////////////

  typedef struct packed {
    logic      illegal_insn;
    alu_op_e   alu_operator;
    op_b_sel_e alu_op_b_mux_sel;
  } decoder_ctrl_t;

  // Decoder output for anything not matched
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    illegal_insn:     1'b1,
    alu_operator:     ALU_B_SH1ADD,
    alu_op_b_mux_sel: OP_B_REG
  };

  // Decode to execute register
  typedef struct packed {
    logic                 valid;
    logic                 illegal;
    alu_op_e              op;
    logic [4:0]           rd;
    logic [`BMU_XLEN-1:0] operand_a;
    logic [`BMU_XLEN-1:0] operand_b;
  } id_ex_t;

  // Unit output
  typedef struct packed {
    logic                 valid;
    logic                 illegal;
    logic [4:0]           rd;
    logic [`BMU_XLEN-1:0] data;
  } bmu_result_t;

endpackage : bmu_pkg

`default_nettype wire

// File: bmu_top.f
+incdir+.
bmu_pkg.sv
b_decoder.sv
bmu_decode_stage.sv
b_alu.sv
bmu_top.sv
tb_bmu_top.sv

// File: bmu_top.sv
// Top level of the bit-manipulation unit, a two-stage pipe of decode then ALU
`timescale 1ns/10ps
`default_nettype none

`include "bmu_config.svh"

module bmu_top (
  input  logic                 clk,
  input  logic                 rst_n_i,   // Synchronous, active low
  input  logic                 valid_i,   // Instruction strobe
  input  logic [31:0]          instr_i,
  input  logic [`BMU_XLEN-1:0] rs1_i,
  input  logic [`BMU_XLEN-1:0] rs2_i,
  output bmu_pkg::bmu_result_t result_o   // Two cycles after issue
);

  bmu_pkg::id_ex_t id_ex; // Decode to ALU register

  //////////////////////////////
  // Stage 1
  //////////////////////////////

  bmu_decode_stage #(
    .B_EXT (`BMU_B_EXT_DEFAULT)
  ) i_bmu_decode_stage (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .instr_i (instr_i),
    .rs1_i   (rs1_i),
    .rs2_i   (rs2_i),
    .id_ex_o (id_ex)
  );

  //////////////////////////////
  // Stage 2
  //////////////////////////////

  b_alu i_b_alu (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .id_ex_i  (id_ex),
    .result_o (result_o)
  );

endmodule : bmu_top

`default_nettype wire

// File: tb_bmu_model.svh
// Reference model of the bit-manipulation unit, included inside the testbench module
`ifndef TB_BMU_MODEL_SVH
`define TB_BMU_MODEL_SVH

localparam int NUM_INSN_CLASSES = 28; // 0-15 register, 16-22 unary, 23-27 immediate

//////////////////////////////
// Encoding table
//////////////////////////////

// Fixed bits of each instruction class, from the ISA encoding tables
function automatic logic [31:0] insn_match(input int cls);
  logic [6:0] f7;
  logic [4:0] f5;
  logic [2:0] f3;
  f7 = 7'd0;
  f5 = 5'd0;  // Only unary ops pin the rs2 field
  f3 = 3'd0;
  case (cls)
    0:  {f7, f3} = {7'b0010000, 3'b010};  // sh1add
    1:  {f7, f3} = {7'b0010000, 3'b100};  // sh2add
    2:  {f7, f3} = {7'b0010000, 3'b110};  // sh3add
    3:  {f7, f3} = {7'b0000101, 3'b100};  // min
    4:  {f7, f3} = {7'b0000101, 3'b101};  // minu
    5:  {f7, f3} = {7'b0000101, 3'b110};  // max
    6:  {f7, f3} = {7'b0000101, 3'b111};  // maxu
    7:  {f7, f3} = {7'b0100000, 3'b111};  // andn
    8:  {f7, f3} = {7'b0100000, 3'b110};  // orn
    9:  {f7, f3} = {7'b0100000, 3'b100};  // xnor
    10: {f7, f3} = {7'b0110000, 3'b001};  // rol
    11: {f7, f3} = {7'b0110000, 3'b101};  // ror
    12: {f7, f3} = {7'b0010100, 3'b001};  // bset
    13: {f7, f3} = {7'b0100100, 3'b001};  // bclr
    14: {f7, f3} = {7'b0110100, 3'b001};  // binv
    15: {f7, f3} = {7'b0100100, 3'b101};  // bext
    16: {f7, f5, f3} = {7'b0110000, 5'b00000, 3'b001};  // clz
    17: {f7, f5, f3} = {7'b0110000, 5'b00001, 3'b001};  // ctz
    18: {f7, f5, f3} = {7'b0110000, 5'b00010, 3'b001};  // cpop
    19: {f7, f5, f3} = {7'b0110000, 5'b00100, 3'b001};  // sext.b
    20: {f7, f5, f3} = {7'b0110000, 5'b00101, 3'b001};  // sext.h
    21: {f7, f5, f3} = {7'b0010100, 5'b00111, 3'b101};  // orc.b
    22: {f7, f5, f3} = {7'b0110100, 5'b11000, 3'b101};  // rev8
    23: {f7, f3} = {7'b0110000, 3'b101};  // rori
    24: {f7, f3} = {7'b0010100, 3'b001};  // bseti
    25: {f7, f3} = {7'b0100100, 3'b001};  // bclri
    26: {f7, f3} = {7'b0110100, 3'b001};  // binvi
    27: {f7, f3} = {7'b0100100, 3'b101};  // bexti
    default: f7 = 7'h7f;
  endcase
  return {f7, f5, 5'd0, f3, 5'd0, (cls < 16) ? 7'h33 : 7'h13};
endfunction

// Which bits of the word are fixed for a class
function automatic logic [31:0] insn_mask(input int cls);
  return (cls >= 16 && cls <= 22) ? 32'hfff0707f : 32'hfe00707f;
endfunction

// Class of a word, or -1 when nothing matches
function automatic int model_decode(input logic [31:0] w);
  int cls;
  cls = -1;
  for (int k = 0; k < NUM_INSN_CLASSES; k++) begin
    if ((w & insn_mask(k)) == insn_match(k)) cls = k;
  end
  return cls;
endfunction

//////////////////////////////
// Operation results
//////////////////////////////

function automatic logic [31:0] model_exec(input int cls, input logic [31:0] a,
                                           input logic [31:0] b);
  logic [4:0]  s;
  logic [31:0] r;
  s = b[4:0];  // Rotate amount and bit index
  r = 32'd0;
  case (cls)
    0:       r = a * 2 + b;
    1:       r = a * 4 + b;
    2:       r = a * 8 + b;
    3:       r = ($signed(a) < $signed(b)) ? a : b;
    4:       r = (a < b) ? a : b;
    5:       r = ($signed(a) > $signed(b)) ? a : b;
    6:       r = (a > b) ? a : b;
    7:       r = a & ~b;
    8:       r = a | ~b;
    9:       r = a ^ ~b;
    10:      r = (a << s) | (a >> (32 - s));  // Shift by 32 gives zero, so s = 0 is safe
    11, 23:  r = (a >> s) | (a << (32 - s));
    12, 24:  r = a | (32'd1 << s);
    13, 25:  r = a & ~(32'd1 << s);
    14, 26:  r = a ^ (32'd1 << s);
    15, 27:  r = (a >> s) & 32'd1;
    16: begin
      r = 32;  // Highest set bit wins
      for (int i = 0; i < 32; i++) if (a[i]) r = 31 - i;
    end
    17: begin
      r = 32;  // Lowest set bit wins
      for (int i = 31; i >= 0; i--) if (a[i]) r = i;
    end
    18: for (int i = 0; i < 32; i++) r = r + {31'd0, a[i]};
    19:      r = {{24{a[7]}}, a[7:0]};
    20:      r = {{16{a[15]}}, a[15:0]};
    21: for (int k = 0; k < 4; k++) r[8*k +: 8] = {8{|a[8*k +: 8]}};
    22:      r = {a[7:0], a[15:8], a[23:16], a[31:24]};
    default: r = 32'd0;
  endcase
  return r;
endfunction

// Expected illegal flag and data for one issued word
function automatic void model_expect(input logic [31:0] w, input logic [31:0] a,
                                     input logic [31:0] b, output logic illegal,
                                     output logic [31:0] data);
  int          cls;
  logic [31:0] opb;
  cls     = model_decode(w);
  illegal = (cls < 0) || (`BMU_B_EXT_DEFAULT == bmu_pkg::B_NONE);
  opb     = (cls >= 23) ? {27'd0, w[24:20]} : b;  // Immediate forms use shamt
  data    = illegal ? 32'd0 : model_exec(cls, a, opb);
endfunction

`endif

// File: tb_bmu_top.sv
// Random self-checking testbench of the bit-manipulation unit, run as the simulation top
`timescale 1ns/10ps
`default_nettype none

`include "bmu_config.svh"

module tb_bmu_top;

  localparam int RESET_CYCLES   = 5;
  localparam int ISSUE_CYCLES   = 2000;
  localparam int TIMEOUT_CYCLES = ISSUE_CYCLES + 100;  // Reset and drain margin

  `include "tb_bmu_model.svh"

  // One expected result, in issue order
  typedef struct packed {
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] due;    // Cycle count at which it must be seen
  } exp_t;

  logic                 clk;
  logic                 rst_n_i;
  logic                 valid_i;
  logic [31:0]          instr_i;
  logic [`BMU_XLEN-1:0] rs1_i;
  logic [`BMU_XLEN-1:0] rs2_i;
  bmu_pkg::bmu_result_t result_o;

  exp_t        exp_q[$];
  exp_t        head;
  int          cycle     = 0;
  logic [31:0] lcg_state = 32'd89;  // Seed

  bmu_top i_bmu_top (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .instr_i  (instr_i),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .result_o (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Random source
  //////////////////////////////

  function automatic logic [15:0] lcg16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];  // Upper half, low bits are weak
  endfunction

  function automatic logic [31:0] rand32();
    return {lcg16(), lcg16()};
  endfunction

  // Mostly random, with zero and all-ones mixed in
  function automatic logic [31:0] pick_operand();
    logic [15:0] r;
    r = lcg16();
    case (r[2:0])
      3'd0:    return 32'd0;
      3'd1:    return 32'hffff_ffff;
      default: return rand32();
    endcase
  endfunction

  //////////////////////////////
  // Failure and checks
  //////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Called at a rising edge, drives one bubble or one instruction
  task automatic issue_cycle();
    logic [15:0] pick;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rnd;
    logic [31:0] data;
    logic        illegal;
    int          cls;
    exp_t        e;
    pick = lcg16();
    if (pick[1:0] == 2'd0) begin
      valid_i <= 1'b0;  // About one cycle in four idle
    end else begin
      rnd = rand32();
      if (pick[4:2] == 3'd0) begin  // About one in eight is illegal
        if (pick[5]) begin
          w = {rnd[31:7], 7'h0b};  // Custom-0 opcode
        end else begin
          w = {7'b0000101, rnd[24:15], 1'b0, rnd[13:7], 7'h33};  // Unused min/max funct3
        end
      end else begin
        cls = lcg16() % NUM_INSN_CLASSES;
        w   = insn_match(cls) | (rnd & ~insn_mask(cls));  // Random rd, rs1, rs2, shamt
      end
      a = pick_operand();
      b = pick_operand();
      model_expect(w, a, b, illegal, data);
      e.illegal = illegal;
      e.rd      = w[11:7];
      e.data    = data;
      e.due     = cycle + 3;  // Sampled next edge, registered the edge after, seen at negedge
      exp_q.push_back(e);
      valid_i <= 1'b1;
      instr_i <= w;
      rs1_i   <= a;
      rs2_i   <= b;
    end
  endtask

  //////////////////////////////
  // Scoreboard and timeout
  //////////////////////////////

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) abort_run("Timeout: the run did not finish in time");
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n_i && result_o.valid) begin
      if (exp_q.size() == 0) begin
        abort_run("Result came out with no instruction outstanding");
      end else begin
        head = exp_q.pop_front();
        check_value("result_o.data", result_o.data, head.data);
        check_value("result_o.rd", {27'd0, result_o.rd}, {27'd0, head.rd});
        check_value("result_o.illegal", {31'd0, result_o.illegal}, {31'd0, head.illegal});
        check_value("result cycle", cycle, head.due);
      end
    end
  end

  initial begin
    rst_n_i = 1'b0;
    valid_i = 1'b0;
    instr_i = 32'd0;
    rs1_i   = '0;
    rs2_i   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check_value("result_o.valid", {31'd0, result_o.valid}, 32'd0);  // Idle after reset
    check_value("result_o.data", result_o.data, 32'd0);
    repeat (ISSUE_CYCLES) begin
      @(posedge clk);
      issue_cycle();
    end
    @(posedge clk);
    valid_i <= 1'b0;
    repeat (4) @(posedge clk);  // Two-stage drain, a stray valid would hit the empty queue
    if (exp_q.size() != 0) begin
      abort_run("Expected results were left over at the end of the run");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule : tb_bmu_top

`default_nettype wire
